//--- build.f
+incdir+.
core_pkg.sv
core_bus_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
hazard_unit.sv
memory_stage.sv
core.sv
tb_core.sv

//--- core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipelined RV32I core top. Instruction memory is
// loaded via imem_*, data memory shared with con_*
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module core import core_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input logic clk,
	input logic reset,

	// Program load, word addressed
	input logic imem_write,
	input logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
	input word_t imem_data,

	// Outside controller port into data memory
	input logic con_write,
	input logic [$clog2(DMEM_WORDS)-1:0] con_addr,
	input word_t con_in,
	output word_t con_out		// Registered, one cycle after con_addr
);

	// Hazard and redirect
	logic stall;
	logic bubble;
	logic redirect;
	pc_t redirect_target;

	// Fetch/decode register
	logic id_valid;
	pc_t id_pc;
	word_t id_inst;

	// Registers read by the instruction in decode
	reg_addr_t rs1;
	reg_addr_t rs2;
	logic uses_rs1;
	logic uses_rs2;

	// Decode/execute register
	logic ex_valid;
	pc_t ex_pc;
	word_t ex_op_a;
	word_t ex_op_b;
	word_t ex_imm;
	reg_addr_t ex_rd;
	reg_addr_t ex_rs1;
	reg_addr_t ex_rs2;
	alu_op_e ex_alu_op;
	wb_sel_e ex_wb_sel;
	logic ex_wr_en;
	logic ex_is_load;
	logic ex_is_store;
	logic ex_is_branch;
	logic ex_is_jump;
	logic [2:0] ex_funct3;
	logic ex_use_imm;

	// Execute/memory register
	logic mem_valid;
	word_t mem_alu;
	word_t mem_store_data;
	reg_addr_t mem_rd;
	logic mem_wr_en;
	wb_sel_e mem_wb_sel;
	logic mem_is_load;
	logic mem_is_store;
	pc_t mem_pc4;

	core_bus_if bus ();		// Memory/writeback results back upstream

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (.*);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (.*);

	hazard_unit u_hazard (.*);		// ex_rd, ex_is_load straight from decode/execute reg

endmodule

//--- core_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Results of the memory and writeback stages, fed
// back for forwarding and the register file write
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface core_bus_if import core_pkg::*; ();

	// Memory stage one cycle behind execute
	reg_addr_t mem_rd;
	logic mem_wr_en;
	word_t mem_result;		// ALU result

	// Writeback stage value going into the register file
	reg_addr_t wb_rd;
	logic wb_wr_en;
	word_t wb_data;

	// Driver side
	modport memory (
		output mem_rd, mem_wr_en, mem_result,
		output wb_rd, wb_wr_en, wb_data
	);

	// Forwarding muxes look at both stages
	modport execute (
		input mem_rd, mem_wr_en, mem_result,
		input wb_rd, wb_wr_en, wb_data
	);

	// Register file write port
	modport decode (
		input wb_rd, wb_wr_en, wb_data
	);

endinterface

//--- core_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes and decode encodings for
// the five-stage RV32I core. Imported by every stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package core_pkg;

	typedef logic [31:0] word_t;		// Data or instruction word
	typedef logic [4:0] reg_addr_t;		// Register number
	typedef logic [31:0] pc_t;			// Byte address, low bits used
	typedef logic [6:0] opcode_t;

	// ALU operation from decode
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	// Writeback source
	typedef enum logic [1:0] {
		WB_ALU,		// ALU result
		WB_LOAD,	// Data memory
		WB_PC4		// Return address for JAL
	} wb_sel_e;

	// Major opcodes handled by the core
	localparam opcode_t OPC_OP = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI = 7'b0110111;
	localparam opcode_t OPC_LOAD = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL = 7'b1101111;

	localparam int INSTR_BYTES = 4;		// No compressed forms

endpackage

//--- decode_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decode, immediates, register file
// and the decode/execute register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
	input logic clk,
	input logic reset,
	input logic id_valid,
	input pc_t id_pc,
	input word_t id_inst,
	input logic bubble,
	input logic stall,
	input logic redirect,
	core_bus_if.decode bus,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output logic uses_rs1,
	output logic uses_rs2,
	output logic ex_valid,
	output pc_t ex_pc,
	output word_t ex_op_a,
	output word_t ex_op_b,
	output word_t ex_imm,
	output reg_addr_t ex_rd,
	output reg_addr_t ex_rs1,
	output reg_addr_t ex_rs2,
	output alu_op_e ex_alu_op,
	output wb_sel_e ex_wb_sel,
	output logic ex_wr_en,
	output logic ex_is_load,
	output logic ex_is_store,
	output logic ex_is_branch,
	output logic ex_is_jump,
	output logic [2:0] ex_funct3,
	output logic ex_use_imm
);

	opcode_t opcode;
	logic [2:0] funct3;
	logic alt;					// inst[30], SUB and SRA select
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t imm;
	alu_op_e alu_op;
	wb_sel_e wb_sel;
	logic wr_en, is_load, is_store, is_branch, is_jump, use_imm, use1, use2;
	logic kill;					// Nothing valid enters execute
	word_t regs [32];
	word_t rf_a, rf_b;

	// Shared by OP and OP_IMM, funct3 picks the operation
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub,
		input logic sra);
		case (f3)
			3'b000: arith_op = sub ? ALU_SUB : ALU_ADD;
			3'b001: arith_op = ALU_SLL;
			3'b010: arith_op = ALU_SLT;
			3'b011: arith_op = ALU_SLTU;
			3'b100: arith_op = ALU_XOR;
			3'b101: arith_op = sra ? ALU_SRA : ALU_SRL;
			3'b110: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	endfunction

	assign opcode = id_inst[6:0];
	assign funct3 = id_inst[14:12];
	assign alt = id_inst[30];

	assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
	assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
	assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
		id_inst[11:8], 1'b0};
	assign imm_u = {id_inst[31:12], 12'b0};
	assign imm_j = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
		id_inst[30:21], 1'b0};

	always_comb begin
		alu_op = ALU_ADD;		// Address add for loads and stores
		wb_sel = WB_ALU;
		imm = imm_i;
		{wr_en, is_load, is_store, is_branch, is_jump, use_imm, use1, use2} = '0;
		case (opcode)
			OPC_OP: begin
				alu_op = arith_op(funct3, alt, alt);
				{wr_en, use1, use2} = '1;
			end
			OPC_OP_IMM: begin
				alu_op = arith_op(funct3, 1'b0, alt);	// No SUBI
				{wr_en, use1, use_imm} = '1;
			end
			OPC_LUI: begin
				imm = imm_u;
				{wr_en, use_imm} = '1;	// x0 + imm, rs1 masked below
			end
			OPC_LOAD: begin
				wb_sel = WB_LOAD;
				{wr_en, use1, use_imm, is_load} = '1;
			end
			OPC_STORE: begin
				imm = imm_s;
				{use1, use2, use_imm, is_store} = '1;
			end
			OPC_BRANCH: begin
				imm = imm_b;
				{use1, use2, is_branch} = '1;
			end
			OPC_JAL: begin
				imm = imm_j;
				wb_sel = WB_PC4;
				{wr_en, is_jump} = '1;
			end
			default: ;				// Unknown opcode retires as a no-op
		endcase
	end

	// Unused source fields read x0, so they never forward or stall
	assign rs1 = use1 ? id_inst[19:15] : '0;
	assign rs2 = use2 ? id_inst[24:20] : '0;
	assign uses_rs1 = id_valid & use1;
	assign uses_rs2 = id_valid & use2;

	// Register file, write from writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (bus.wb_wr_en && bus.wb_rd != '0) begin
			regs[bus.wb_rd] <= bus.wb_data;
		end
	end

	// Same-cycle write shows through
	assign rf_a = (bus.wb_wr_en && bus.wb_rd != '0 && bus.wb_rd == rs1) ? bus.wb_data : regs[rs1];
	assign rf_b = (bus.wb_wr_en && bus.wb_rd != '0 && bus.wb_rd == rs2) ? bus.wb_data : regs[rs2];

	assign kill = bubble | redirect | ~id_valid;

	// Valid and side-effect flags
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			{ex_wr_en, ex_is_load, ex_is_store, ex_is_branch, ex_is_jump} <= '0;
		end else begin
			ex_valid <= ~kill;
			ex_wr_en <= wr_en & ~kill;
			ex_is_load <= is_load & ~kill;
			ex_is_store <= is_store & ~kill;
			ex_is_branch <= is_branch & ~kill;
			ex_is_jump <= is_jump & ~kill;
		end
	end

	// Payload held while stalled, the bubble carries no work
	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_pc <= id_pc;
			ex_op_a <= rf_a;
			ex_op_b <= rf_b;
			ex_imm <= imm;
			ex_rd <= id_inst[11:7];
			ex_rs1 <= rs1;
			ex_rs2 <= rs2;
			ex_alu_op <= alu_op;
			ex_wb_sel <= wb_sel;
			ex_funct3 <= funct3;
			ex_use_imm <= use_imm;
		end
	end

endmodule

//--- execute_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Forwarding, ALU, branch resolution and the
// execute/memory register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
	input logic clk,
	input logic reset,
	input logic ex_valid,
	input pc_t ex_pc,
	input word_t ex_op_a,
	input word_t ex_op_b,
	input word_t ex_imm,
	input reg_addr_t ex_rd,
	input reg_addr_t ex_rs1,
	input reg_addr_t ex_rs2,
	input alu_op_e ex_alu_op,
	input wb_sel_e ex_wb_sel,
	input logic ex_wr_en,
	input logic ex_is_load,
	input logic ex_is_store,
	input logic ex_is_branch,
	input logic ex_is_jump,
	input logic [2:0] ex_funct3,
	input logic ex_use_imm,
	core_bus_if.execute bus,
	output logic redirect,			// One-cycle pulse
	output pc_t redirect_target,
	output logic mem_valid,
	output word_t mem_alu,
	output word_t mem_store_data,
	output reg_addr_t mem_rd,
	output logic mem_wr_en,
	output wb_sel_e mem_wb_sel,
	output logic mem_is_load,
	output logic mem_is_store,
	output pc_t mem_pc4
);

	word_t fwd_a, fwd_b;		// Register operands after forwarding
	word_t alu_b;
	word_t alu_out;
	logic cond;					// Branch condition from funct3

	// Memory stage first, then writeback, else decode's read
	function automatic word_t fwd(input reg_addr_t rs, input word_t rf_val);
		if (rs == '0)
			fwd = rf_val;
		else if (bus.mem_wr_en && bus.mem_rd == rs)
			fwd = bus.mem_result;
		else if (bus.wb_wr_en && bus.wb_rd == rs)
			fwd = bus.wb_data;
		else
			fwd = rf_val;
	endfunction

	always_comb begin
		fwd_a = fwd(ex_rs1, ex_op_a);
		fwd_b = fwd(ex_rs2, ex_op_b);
	end

	assign alu_b = ex_use_imm ? ex_imm : fwd_b;

	always_comb begin
		case (ex_alu_op)
			ALU_SUB: alu_out = fwd_a - alu_b;
			ALU_AND: alu_out = fwd_a & alu_b;
			ALU_OR: alu_out = fwd_a | alu_b;
			ALU_XOR: alu_out = fwd_a ^ alu_b;
			ALU_SLT: alu_out = word_t'($signed(fwd_a) < $signed(alu_b));
			ALU_SLTU: alu_out = word_t'(fwd_a < alu_b);
			ALU_SLL: alu_out = fwd_a << alu_b[4:0];
			ALU_SRL: alu_out = fwd_a >> alu_b[4:0];
			ALU_SRA: alu_out = word_t'($signed(fwd_a) >>> alu_b[4:0]);
			default: alu_out = fwd_a + alu_b;	// ADD, address, LUI
		endcase
	end

	always_comb begin
		case (ex_funct3)
			3'b000: cond = (fwd_a == fwd_b);		// BEQ
			3'b001: cond = (fwd_a != fwd_b);		// BNE
			3'b100: cond = ($signed(fwd_a) < $signed(fwd_b));	// BLT
			3'b101: cond = ($signed(fwd_a) >= $signed(fwd_b));	// BGE
			default: cond = 1'b0;
		endcase
	end

	assign redirect = ex_valid & (ex_is_jump | (ex_is_branch & cond));
	assign redirect_target = ex_pc + ex_imm;	// Same adder for branch and JAL

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_valid <= 1'b0;
			{mem_wr_en, mem_is_load, mem_is_store} <= '0;
		end else begin
			mem_valid <= ex_valid;
			mem_wr_en <= ex_wr_en;
			mem_is_load <= ex_is_load;
			mem_is_store <= ex_is_store;
		end
	end

	always_ff @(posedge clk) begin
		mem_alu <= alu_out;
		mem_store_data <= fwd_b;		// SW data is rs2
		mem_rd <= ex_rd;
		mem_wb_sel <= ex_wb_sel;
		mem_pc4 <= ex_pc + pc_t'(INSTR_BYTES);	// JAL link
	end

endmodule

//--- fetch_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter, instruction memory and the
// fetch/decode register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fetch_stage import core_pkg::*; #(
	parameter int IMEM_WORDS = 256
) (
	input logic clk,
	input logic reset,
	input logic stall,				// Load-use hold
	input logic redirect,			// Taken branch or JAL in execute
	input pc_t redirect_target,
	input logic imem_write,
	input logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
	input word_t imem_data,
	output logic id_valid,
	output pc_t id_pc,
	output word_t id_inst
);

	localparam int IA = $clog2(IMEM_WORDS);		// Word index width

	word_t imem [IMEM_WORDS];
	pc_t pc;					// Address being fetched this cycle

	// Loader port
	always_ff @(posedge clk) begin
		if (imem_write)
			imem[imem_addr] <= imem_data;
	end

	// Redirect beats stall, the hazard unit never raises both
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			id_valid <= 1'b0;
		end else if (redirect) begin
			pc <= redirect_target;
			id_valid <= 1'b0;		// Kill the wrong-path fetch
		end else if (!stall) begin
			pc <= pc + pc_t'(INSTR_BYTES);
			id_valid <= 1'b1;
		end
	end

	// Synchronous read lands directly in the fetch/decode register
	always_ff @(posedge clk) begin
		if (!stall) begin
			id_inst <= imem[pc[IA+1:2]];
			id_pc <= pc;
		end
	end

endmodule

//--- hazard_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load-use detection, one bubble per hit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module hazard_unit import core_pkg::*; (
	input reg_addr_t rs1,		// From the instruction in decode
	input reg_addr_t rs2,
	input logic uses_rs1,
	input logic uses_rs2,
	input reg_addr_t ex_rd,		// Instruction in execute
	input logic ex_is_load,
	input logic redirect,
	output logic stall,			// Hold PC and fetch/decode
	output logic bubble			// Empty decode/execute
);

	logic hit_a;
	logic hit_b;
	logic load_use;

	// Load data only exists at writeback, too late for the next instruction
	assign hit_a = uses_rs1 && (rs1 == ex_rd);
	assign hit_b = uses_rs2 && (rs2 == ex_rd);
	assign load_use = ex_is_load && (ex_rd != '0) && (hit_a || hit_b);

	// A flushed consumer needs no wait
	assign stall = load_use & ~redirect;
	assign bubble = stall;		// One bubble while the load moves to memory

endmodule

//--- memory_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-port data memory, memory/writeback register
// and writeback select. con_* port wins a clash
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module memory_stage import core_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input logic clk,
	input logic reset,
	input logic mem_valid,
	input word_t mem_alu,			// Result or byte address
	input word_t mem_store_data,
	input reg_addr_t mem_rd,
	input logic mem_wr_en,
	input wb_sel_e mem_wb_sel,
	input logic mem_is_load,
	input logic mem_is_store,
	input pc_t mem_pc4,
	input logic con_write,
	input logic [$clog2(DMEM_WORDS)-1:0] con_addr,
	input word_t con_in,
	output word_t con_out,
	core_bus_if.memory bus
);

	localparam int DA = $clog2(DMEM_WORDS);

	word_t dmem [DMEM_WORDS];
	logic [DA-1:0] core_idx;		// Word index from the ALU
	word_t load_q;					// Read data for writeback
	word_t wb_alu;
	pc_t wb_pc4;
	wb_sel_e wb_sel;

	assign core_idx = mem_alu[DA+1:2];

	// Core port on mem_alu and controller port on con_addr
	always_ff @(posedge clk) begin
		if (mem_is_store && !(con_write && con_addr == core_idx))
			dmem[core_idx] <= mem_store_data;
		if (con_write)
			dmem[con_addr] <= con_in;
		if (mem_is_load)
			load_q <= dmem[core_idx];
		con_out <= dmem[con_addr];
	end

	// Results visible to forwarding
	assign bus.mem_rd = mem_rd;
	assign bus.mem_wr_en = mem_wr_en;
	assign bus.mem_result = mem_alu;		// Slot behind a JAL is always flushed

	always_ff @(posedge clk) begin
		if (reset)
			bus.wb_wr_en <= 1'b0;
		else
			bus.wb_wr_en <= mem_valid & mem_wr_en;
	end

	always_ff @(posedge clk) begin
		bus.wb_rd <= mem_rd;
		wb_alu <= mem_alu;
		wb_pc4 <= mem_pc4;
		wb_sel <= mem_wb_sel;
	end

	// Writeback select
	always_comb begin
		case (wb_sel)
			WB_LOAD: bus.wb_data = load_q;
			WB_PC4: bus.wb_data = wb_pc4;
			default: bus.wb_data = wb_alu;
		endcase
	end

endmodule

//--- tb_core_programs.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Test program image, result slots and encoders.
// Included inside the testbench module body
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_CORE_PROGRAMS_SVH
`define TB_CORE_PROGRAMS_SVH

// Data memory byte addresses
localparam int CON_SRC_ADDR = 32;		// Word 8, preloaded over con_*
localparam int CHAIN_BASE = 64;			// 17 ALU chain results
localparam int LOAD_USE_ADDR = 136;
localparam int STORE_USE_ADDR = 140;
localparam int ZERO_ADDR = 144;
localparam int POISON_ADDR = 148;		// x9, shadow writes land here
localparam int COUNT_ADDR = 152;		// Not-taken fall-through count
localparam int LINK_ADDR = 156;
localparam int CON_COPY_ADDR = 160;
localparam int DONE_ADDR = 252;

localparam logic [31:0] DONE_MARK = 32'h600D_0000;
localparam logic [31:0] CON_WORD = 32'h5EED_C0DE;
localparam int POISON = 'h666;

logic [31:0] prog [$];		// Instruction words, index is word address
int jal_pc;					// Byte address of the JAL

// RV32I encoders
function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
	input int rd, input int rs1, input int rs2);
	return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] imm_op(input logic [2:0] f3, input int rd, input int rs1,
	input int imm);
	return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
endfunction

function automatic logic [31:0] load_word(input int rd, input int rs1, input int off);
	return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
endfunction

function automatic logic [31:0] store_word(input int rs2, input int rs1, input int off);
	return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
	input int off);
	return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] lui(input int rd, input logic [19:0] upper);
	return {upper, rd[4:0], 7'b0110111};
endfunction

function automatic logic [31:0] jal(input int rd, input int off);
	return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
endfunction

task automatic emit(input logic [31:0] word);
	prog.push_back(word);
endtask

// Taken branch over two poison writes, then a not-taken one over the count
task automatic branch_pair(input logic [2:0] f3, input int take_a, input int take_b,
	input int skip_a, input int skip_b);
	emit(branch(f3, take_a, take_b, 12));
	emit(imm_op(3'b000, 9, 0, POISON));
	emit(imm_op(3'b000, 9, 0, POISON));
	emit(branch(f3, skip_a, skip_b, 8));
	emit(imm_op(3'b000, 10, 10, 1));		// Skipped only if wrongly taken
endtask

task automatic build_program();
	prog.delete();
	for (int i = 0; i < 8; i++)
		emit(load_word(i + 1, 0, 4 * i));	// Operands into x1..x8

	// Dependent chain, each result in x15+i
	emit(reg_op(7'h00, 3'b000, 15, 1, 2));		// ADD
	emit(reg_op(7'h20, 3'b000, 16, 15, 3));	// SUB
	emit(reg_op(7'h00, 3'b111, 17, 16, 4));	// AND
	emit(reg_op(7'h00, 3'b110, 18, 17, 5));	// OR
	emit(reg_op(7'h00, 3'b100, 19, 18, 6));	// XOR
	emit(reg_op(7'h00, 3'b010, 20, 19, 7));	// SLT
	emit(reg_op(7'h00, 3'b011, 21, 7, 19));	// SLTU, x19 two back
	emit(reg_op(7'h00, 3'b001, 22, 8, 19));	// SLL
	emit(reg_op(7'h00, 3'b101, 23, 22, 2));	// SRL
	emit(reg_op(7'h20, 3'b101, 24, 22, 3));	// SRA
	emit(imm_op(3'b000, 25, 24, -1234));		// ADDI
	emit(imm_op(3'b100, 26, 25, 'h5A5));		// XORI
	emit(imm_op(3'b110, 27, 26, -16));			// ORI
	emit(imm_op(3'b111, 28, 26, 'h6C3));		// ANDI
	emit(imm_op(3'b010, 29, 24, 100));			// SLTI
	emit(lui(30, 20'hABCDE));
	emit(reg_op(7'h00, 3'b000, 31, 30, 19));	// LUI result from memory stage
	for (int i = 16; i >= 0; i--)
		emit(store_word(15 + i, 0, CHAIN_BASE + 4 * i));

	// Load-use, once through an ADD and once through store data
	emit(load_word(11, 0, 8));
	emit(load_word(12, 0, 12));
	emit(reg_op(7'h00, 3'b000, 13, 11, 12));
	emit(store_word(13, 0, LOAD_USE_ADDR));
	emit(load_word(14, 0, 16));
	emit(store_word(14, 0, STORE_USE_ADDR));

	emit(imm_op(3'b000, 0, 0, 123));		// Must not stick in x0
	emit(store_word(0, 0, ZERO_ADDR));

	// Known pairs, x11 = x12 = 5, x13 = -3, x14 = 7
	emit(imm_op(3'b000, 11, 0, 5));
	emit(imm_op(3'b000, 12, 0, 5));
	emit(imm_op(3'b000, 13, 0, -3));
	emit(imm_op(3'b000, 14, 0, 7));
	branch_pair(3'b000, 11, 12, 11, 14);	// BEQ
	branch_pair(3'b001, 11, 14, 11, 12);	// BNE
	branch_pair(3'b100, 13, 11, 14, 11);	// BLT, signed
	branch_pair(3'b101, 14, 11, 13, 11);	// BGE
	jal_pc = prog.size() * 4;
	emit(jal(1, 12));
	emit(imm_op(3'b000, 9, 0, POISON));
	emit(imm_op(3'b000, 9, 0, POISON));
	emit(store_word(9, 0, POISON_ADDR));
	emit(store_word(10, 0, COUNT_ADDR));
	emit(store_word(1, 0, LINK_ADDR));

	emit(load_word(2, 0, CON_SRC_ADDR));	// Word from the controller
	emit(store_word(2, 0, CON_COPY_ADDR));
	emit(lui(3, DONE_MARK[31:12]));
	emit(store_word(3, 0, DONE_ADDR));		// Last store
	emit(jal(0, 0));						// Park
endtask

`endif

//--- tb_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the pipelined RV32I core. Loads a
// program, runs it, checks results over con_*
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_core;

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int IA = $clog2(IMEM_WORDS);
	localparam int DA = $clog2(DMEM_WORDS);
	localparam int DONE_TIMEOUT = 2000;		// Cycles

	logic clk;
	logic reset;
	logic imem_write;
	logic [IA-1:0] imem_addr;
	logic [31:0] imem_data;
	logic con_write;
	logic [DA-1:0] con_addr;
	logic [31:0] con_in;
	logic [31:0] con_out;

	logic [31:0] lfsr = 32'h6152_fccd;
	logic [31:0] operand [8];		// Words at data memory 0..7
	logic [31:0] exp_chain [17];
	logic done;

	`include "tb_core_programs.svh"

	core #(
		.IMEM_WORDS(IMEM_WORDS),
		.DMEM_WORDS(DMEM_WORDS)
	) DUT (
		.clk(clk),
		.reset(reset),
		.imem_write(imem_write),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.con_out(con_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic random_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr = lfsr_next(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	// RV32I results of the chain, straight from the operands
	task automatic compute_expected();
		exp_chain[0] = operand[0] + operand[1];
		exp_chain[1] = exp_chain[0] - operand[2];
		exp_chain[2] = exp_chain[1] & operand[3];
		exp_chain[3] = exp_chain[2] | operand[4];
		exp_chain[4] = exp_chain[3] ^ operand[5];
		exp_chain[5] = ($signed(exp_chain[4]) < $signed(operand[6])) ? 32'd1 : 32'd0;
		exp_chain[6] = (operand[6] < exp_chain[4]) ? 32'd1 : 32'd0;
		exp_chain[7] = operand[7] << exp_chain[4][4:0];
		exp_chain[8] = exp_chain[7] >> operand[1][4:0];
		exp_chain[9] = $signed(exp_chain[7]) >>> operand[2][4:0];	// Sign fill
		exp_chain[10] = exp_chain[9] - 32'd1234;
		exp_chain[11] = exp_chain[10] ^ 32'h0000_05A5;
		exp_chain[12] = exp_chain[11] | 32'hFFFF_FFF0;		// -16 sign extended
		exp_chain[13] = exp_chain[11] & 32'h0000_06C3;
		exp_chain[14] = ($signed(exp_chain[9]) < 100) ? 32'd1 : 32'd0;
		exp_chain[15] = 32'hABCD_E000;
		exp_chain[16] = exp_chain[15] + exp_chain[4];
	endtask

	// Present the address, con_out holds the word one cycle later
	task automatic check_slot(input string name, input int byte_addr,
		input logic [31:0] expected);
		logic [31:0] actual;
		@(posedge clk);
		con_addr <= DA'(byte_addr / 4);
		@(posedge clk);			// Address taken here
		@(negedge clk);
		actual = con_out;
		assert (actual === expected) else begin
			$display("TESTS FAILED");
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$fatal(1, "result check failed");
		end
	endtask

	initial begin
		reset = 1'b1;
		imem_write = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		con_write = 1'b0;
		con_addr = '0;
		con_in = '0;
		done = 1'b0;
		build_program();
		for (int i = 0; i < 8; i++)
			random_word(operand[i]);
		compute_expected();

		// Program image while reset is held
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			imem_write <= 1'b1;
			imem_addr <= IA'(i);
			imem_data <= prog[i];
		end
		@(posedge clk);
		imem_write <= 1'b0;

		// Operand words, controller word, cleared done slot
		for (int i = 0; i < 8; i++) begin
			con_write <= 1'b1;
			con_addr <= DA'(i);
			con_in <= operand[i];
			@(posedge clk);
		end
		con_addr <= DA'(CON_SRC_ADDR / 4);
		con_in <= CON_WORD;
		@(posedge clk);
		con_addr <= DA'(DONE_ADDR / 4);
		con_in <= '0;
		@(posedge clk);
		con_write <= 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// Poll the done slot, address stays put
		for (int n = 0; n < DONE_TIMEOUT && !done; n++) begin
			@(negedge clk);
			if (con_out === DONE_MARK)
				done = 1'b1;
		end
		if (!done) begin
			$display("TESTS FAILED");
			$display("Timeout: the program never wrote its done marker");
			$fatal(1, "timeout");
		end

		for (int i = 0; i < 17; i++)
			check_slot($sformatf("alu_chain_%0d", i), CHAIN_BASE + 4 * i, exp_chain[i]);
		check_slot("load_use_add", LOAD_USE_ADDR, operand[2] + operand[3]);
		check_slot("load_use_store", STORE_USE_ADDR, operand[4]);
		check_slot("x0_write", ZERO_ADDR, 32'd0);
		check_slot("branch_shadow", POISON_ADDR, 32'd0);	// Poison never retired
		check_slot("branch_count", COUNT_ADDR, 32'd4);		// Four not-taken branches
		check_slot("jal_link", LINK_ADDR, jal_pc + 4);
		check_slot("con_preload", CON_COPY_ADDR, CON_WORD);
		$display("TESTS PASSED");
		$finish;
	end

endmodule
